//--- logic/cfo_fmt_pkg.sv
`default_nettype none

package cfo_fmt_pkg;

    // one signed real or imaginary component
    localparam int COMP_W = 16;

    typedef logic [COMP_W-1:0] comp_t;

    // complex value, imaginary part in the upper half
    typedef logic [2*COMP_W-1:0] corr_t;

    // one component of the truncated Q15 product
    typedef logic [COMP_W-1:0] prod_t;

    // common left shift applied to both inputs
    typedef logic [3:0] shift_t;

endpackage

`default_nettype wire

//--- logic/cfo_angle_pkg.sv
`default_nettype none

package cfo_angle_pkg;

    // arctangent table index
    localparam int IDX_W   = 10;
    localparam int LUT_MAX = 2**IDX_W - 1;

    typedef logic [IDX_W-1:0] lut_idx_t;

    // bit positions inside octant_t
    localparam int OCT_SWAP   = 2;
    localparam int OCT_NEG_RE = 1;
    localparam int OCT_NEG_IM = 0;

    typedef logic [2:0] octant_t;

    typedef enum logic [2:0] {IDLE, NORM, MULT, FOLD, DIV, ATAN, HOLD} cfo_state_e;

endpackage

`default_nettype wire

//--- logic/cfo_if.sv
`timescale 1ns/100ps
`default_nettype none

// complex multiply, one start pulse per operation
interface cfo_mult_if import cfo_fmt_pkg::*; ();
    logic  start;
    corr_t a;
    corr_t b;
    prod_t prod_re;
    prod_t prod_im;
    logic  done;

    modport ctrl (output start, a, b, input prod_re, prod_im, done);
    modport unit (input start, a, b, output prod_re, prod_im, done);
endinterface

// serial divide for the table index
interface cfo_div_if import cfo_fmt_pkg::*, cfo_angle_pkg::*; ();
    logic     start;
    prod_t    num;
    prod_t    den;
    lut_idx_t quot;
    logic     done;

    modport ctrl (output start, num, den, input quot, done);
    modport unit (input start, num, den, output quot, done);
endinterface

`default_nettype wire

//--- logic/cfo_control.sv
`timescale 1ns/100ps
`default_nettype none

module cfo_control
    import cfo_fmt_pkg::*, cfo_angle_pkg::*;
#(
    parameter int ANGLE_W = 20,
    parameter int DDS_W   = 20
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  corr_t                     c0_i,
    input  corr_t                     c1_i,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  logic                      out_ready_i,
    output logic                      out_valid_o,
    output logic signed [ANGLE_W-1:0] angle_o,
    output logic signed [DDS_W-1:0]   dds_inc_o,
    input  shift_t                    shift_i,
    cfo_mult_if.ctrl                  mult,
    cfo_div_if.ctrl                   div,
    output prod_t                     prod_re_o,
    output prod_t                     prod_im_o,
    input  prod_t                     num_i,
    input  prod_t                     den_i,
    input  octant_t                   octant_i,
    output octant_t                   octant_o,
    output lut_idx_t                  idx_o,
    input  logic signed [ANGLE_W-1:0] angle_i
);

    cfo_state_e               state_q;
    corr_t                    a_q;
    corr_t                    b_q;
    logic                     mult_start_q;
    logic                     div_start_q;
    prod_t                    prod_re_q;
    prod_t                    prod_im_q;
    prod_t                    num_q;
    prod_t                    den_q;
    octant_t                  octant_q;
    logic signed [DDS_W-1:0]  dds_next;

    // same left shift on both components of one value
    function automatic corr_t shift_corr(corr_t c, shift_t s);
        comp_t im;
        comp_t re;
        im = c[2*COMP_W-1:COMP_W] << s;
        re = c[COMP_W-1:0] << s;
        return {im, re};
    endfunction

    // DDS increment is the angle divided by 64
    if (ANGLE_W >= DDS_W) begin : g_dds_msb
        assign dds_next = $signed(angle_i[ANGLE_W-1 -: DDS_W]) >>> 6;
    end else begin : g_dds_ext
        assign dds_next = $signed({{(DDS_W-ANGLE_W){angle_i[ANGLE_W-1]}}, angle_i}) >>> 6;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= IDLE;
            mult_start_q <= 1'b0;
            div_start_q  <= 1'b0;
            out_valid_o  <= 1'b0;
            angle_o      <= '0;
            dds_inc_o    <= '0;
        end else begin
            mult_start_q <= 1'b0;
            div_start_q  <= 1'b0;
            case (state_q)
                IDLE: if (in_valid_i) state_q <= NORM;
                NORM: begin
                    mult_start_q <= 1'b1;
                    state_q      <= MULT;
                end
                // done arrives one cycle after start
                MULT: if (mult.done) state_q <= FOLD;
                FOLD: begin
                    div_start_q <= 1'b1;
                    state_q     <= DIV;
                end
                DIV:  if (div.done) state_q <= ATAN;
                ATAN: begin
                    angle_o     <= angle_i;
                    dds_inc_o   <= dds_next;
                    out_valid_o <= 1'b1;
                    state_q     <= HOLD;
                end
                HOLD: if (out_ready_i) begin
                    out_valid_o <= 1'b0;
                    state_q     <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // operand registers
    always_ff @(posedge clk_i) begin
        // raw pair first, so the normalizer sees it during NORM
        if (state_q == IDLE && in_valid_i) begin
            a_q <= c0_i;
            b_q <= c1_i;
        end
        if (state_q == NORM) begin
            a_q <= shift_corr(a_q, shift_i);
            b_q <= shift_corr(b_q, shift_i);
        end
        if (state_q == MULT && mult.done) begin
            prod_re_q <= mult.prod_re;
            prod_im_q <= mult.prod_im;
        end
        if (state_q == FOLD) begin
            num_q    <= num_i;
            den_q    <= den_i;
            octant_q <= octant_i;
        end
    end

    assign in_ready_o = (state_q == IDLE);

    assign mult.start = mult_start_q;
    assign mult.a     = a_q;
    assign mult.b     = b_q;

    assign div.start = div_start_q;
    assign div.num   = num_q;
    assign div.den   = den_q;

    assign prod_re_o = prod_re_q;
    assign prod_im_o = prod_im_q;
    assign octant_o  = octant_q;
    assign idx_o     = div.quot;

endmodule

`default_nettype wire

//--- logic/cfo_normalize.sv
`timescale 1ns/100ps
`default_nettype none

module cfo_normalize import cfo_fmt_pkg::*; (
    input  corr_t  c0_i,
    input  corr_t  c1_i,
    output shift_t shift_o
);

    // bits below the MSB that only repeat the sign, at most 14
    function automatic shift_t spare_bits(comp_t c);
        shift_t n;
        logic   run;
        n   = '0;
        run = 1'b1;
        for (int i = COMP_W - 2; i >= 1; i--) begin
            if (run && c[i] == c[COMP_W-1]) begin
                n = n + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
        return n;
    endfunction

    shift_t s0_im, s0_re, s1_im, s1_re;
    shift_t min_0, min_1;

    assign s0_im = spare_bits(c0_i[2*COMP_W-1:COMP_W]);
    assign s0_re = spare_bits(c0_i[COMP_W-1:0]);
    assign s1_im = spare_bits(c1_i[2*COMP_W-1:COMP_W]);
    assign s1_re = spare_bits(c1_i[COMP_W-1:0]);

    // the largest component sets the common shift
    assign min_0   = (s0_im < s0_re) ? s0_im : s0_re;
    assign min_1   = (s1_im < s1_re) ? s1_im : s1_re;
    assign shift_o = (min_0 < min_1) ? min_0 : min_1;

endmodule

`default_nettype wire

//--- logic/cfo_conj_mult.sv
`timescale 1ns/100ps
`default_nettype none

module cfo_conj_mult import cfo_fmt_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_ni,
    cfo_mult_if.unit mult
);

    logic signed [COMP_W-1:0] a_re, a_im, b_re, b_im;
    logic signed [2*COMP_W:0] re_full, im_full;

    assign a_im = mult.a[2*COMP_W-1:COMP_W];
    assign a_re = mult.a[COMP_W-1:0];
    assign b_im = mult.b[2*COMP_W-1:COMP_W];
    assign b_re = mult.b[COMP_W-1:0];

    // a * conj(b) = (ar*br + ai*bi) + j(ai*br - ar*bi)
    assign re_full = a_re * b_re + a_im * b_im;
    assign im_full = a_im * b_re - a_re * b_im;

    // Q15 result, bits 30 down to 15
    always_ff @(posedge clk_i) begin
        if (mult.start) begin
            mult.prod_re <= re_full[2*COMP_W-2 -: COMP_W];
            mult.prod_im <= im_full[2*COMP_W-2 -: COMP_W];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            mult.done <= 1'b0;
        end else begin
            mult.done <= mult.start;
        end
    end

endmodule

`default_nettype wire

//--- logic/cfo_divider.sv
`timescale 1ns/100ps
`default_nettype none

module cfo_divider import cfo_fmt_pkg::*, cfo_angle_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_ni,
    cfo_div_if.unit div
);

    localparam int CNT_W = $clog2(IDX_W + 1);

    logic [CNT_W-1:0] count_q;
    logic [COMP_W:0]  rem_q;
    logic [COMP_W:0]  rem_shift;
    prod_t            den_q;
    logic             fill_q;
    logic             q_bit;

    // dividend is num*2^10 - 1, i.e. num-1 on top and ten fill bits of 1
    // num = 0 gives a zero dividend and zero fill
    assign rem_shift = {rem_q[COMP_W-1:0], fill_q};
    assign q_bit     = (den_q != '0) && (rem_shift >= {1'b0, den_q});

    always_ff @(posedge clk_i) begin
        if (div.start) begin
            rem_q  <= (div.num != '0) ? {1'b0, div.num - 1'b1} : '0;
            fill_q <= (div.num != '0);
            den_q  <= div.den;
        end else if (count_q != '0) begin
            rem_q <= q_bit ? rem_shift - {1'b0, den_q} : rem_shift;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            count_q  <= '0;
            div.quot <= '0;
            div.done <= 1'b0;
        end else begin
            div.done <= 1'b0;
            if (div.start) begin
                count_q  <= CNT_W'(IDX_W);
                div.quot <= '0;
            end else if (count_q != '0) begin
                // one quotient bit per cycle, MSB first
                count_q  <= count_q - 1'b1;
                div.quot <= {div.quot[IDX_W-2:0], q_bit};
                div.done <= (count_q == CNT_W'(1));
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/cfo_atan.sv
`timescale 1ns/100ps
`default_nettype none

module cfo_atan
    import cfo_fmt_pkg::*, cfo_angle_pkg::*;
#(
    parameter int ANGLE_W = 20
) (
    input  prod_t                     prod_re_i,
    input  prod_t                     prod_im_i,
    output prod_t                     num_o,
    output prod_t                     den_o,
    output octant_t                   octant_o,
    input  lut_idx_t                  idx_i,
    input  octant_t                   octant_i,
    output logic signed [ANGLE_W-1:0] angle_o
);

    localparam logic signed [ANGLE_W-1:0] PI_HALF    = 2**(ANGLE_W-2) - 1;
    localparam logic signed [ANGLE_W-1:0] PI_QUARTER = 2**(ANGLE_W-3) - 1;
    localparam real PI_R = 3.14159265358979;

    logic [ANGLE_W-1:0] atan_lut [0:LUT_MAX];

    prod_t                     mag_re, mag_im;
    logic                      swap;
    logic signed [ANGLE_W-1:0] lut_val;
    logic signed [ANGLE_W-1:0] first_quad;

    // atan(i/1023) with pi/4 at PI_QUARTER
    initial begin
        real v;
        for (int i = 0; i <= LUT_MAX; i++) begin
            v = $atan(real'(i) / real'(LUT_MAX)) * 4.0 / PI_R * real'(PI_QUARTER);
            atan_lut[i] = ANGLE_W'($rtoi(v + 0.5));
        end
    end

    // fold into the first octant, 0x8000 maps to 32768 unsigned
    assign mag_re = prod_re_i[COMP_W-1] ? -prod_re_i : prod_re_i;
    assign mag_im = prod_im_i[COMP_W-1] ? -prod_im_i : prod_im_i;
    assign swap   = (mag_re <= mag_im);

    assign num_o    = swap ? mag_re : mag_im;
    assign den_o    = swap ? mag_im : mag_re;
    assign octant_o = {swap, prod_re_i[COMP_W-1], prod_im_i[COMP_W-1]};

    // swapped octant mirrors about pi/4
    assign lut_val    = $signed(atan_lut[idx_i]);
    assign first_quad = octant_i[OCT_SWAP] ? PI_QUARTER + (PI_QUARTER - lut_val) : lut_val;

    // quadrant unfold, pi taken as two PI_HALF
    always_comb begin
        case ({octant_i[OCT_NEG_IM], octant_i[OCT_NEG_RE]})
            2'b00:   angle_o = first_quad;
            2'b01:   angle_o = PI_HALF + (PI_HALF - first_quad);
            2'b11:   angle_o = first_quad - PI_HALF - PI_HALF;
            default: angle_o = -first_quad;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/cfo_estimator.sv
`timescale 1ns/100ps
`default_nettype none

module cfo_estimator
    import cfo_fmt_pkg::*, cfo_angle_pkg::*;
#(
    parameter int ANGLE_W = 20,
    parameter int DDS_W   = 20
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  corr_t                     c0_i,
    input  corr_t                     c1_i,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    output logic signed [ANGLE_W-1:0] angle_o,
    output logic signed [DDS_W-1:0]   dds_inc_o,
    output logic                      out_valid_o,
    input  logic                      out_ready_i
);

    shift_t                    shift;
    prod_t                     prod_re, prod_im;
    prod_t                     num, den;
    octant_t                   octant_fold, octant_held;
    lut_idx_t                  idx;
    logic signed [ANGLE_W-1:0] angle;

    cfo_mult_if u_mult_if ();
    cfo_div_if  u_div_if ();

    cfo_control #(
        .ANGLE_W (ANGLE_W),
        .DDS_W   (DDS_W)
    ) u_control (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .c0_i        (c0_i),
        .c1_i        (c1_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .angle_o     (angle_o),
        .dds_inc_o   (dds_inc_o),
        .shift_i     (shift),
        .mult        (u_mult_if.ctrl),
        .div         (u_div_if.ctrl),
        .prod_re_o   (prod_re),
        .prod_im_o   (prod_im),
        .num_i       (num),
        .den_i       (den),
        .octant_i    (octant_fold),
        .octant_o    (octant_held),
        .idx_o       (idx),
        .angle_i     (angle)
    );

    // the multiplier operands hold the raw pair while in NORM
    cfo_normalize u_normalize (
        .c0_i    (u_mult_if.a),
        .c1_i    (u_mult_if.b),
        .shift_o (shift)
    );

    cfo_conj_mult u_conj_mult (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .mult     (u_mult_if.unit)
    );

    cfo_divider u_divider (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .div      (u_div_if.unit)
    );

    cfo_atan #(
        .ANGLE_W (ANGLE_W)
    ) u_atan (
        .prod_re_i (prod_re),
        .prod_im_i (prod_im),
        .num_o     (num),
        .den_o     (den),
        .octant_o  (octant_fold),
        .idx_i     (idx),
        .octant_i  (octant_held),
        .angle_o   (angle)
    );

endmodule

`default_nettype wire

//--- verification/tb_cfo_estimator.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cfo_estimator;

    localparam int ANGLE_W = 20;
    localparam int DDS_W   = 20;

    logic                      clk_i = 1'b0;
    logic                      reset_ni;
    logic [31:0]               c0_i;
    logic [31:0]               c1_i;
    logic                      in_valid_i;
    logic                      in_ready_o;
    logic signed [ANGLE_W-1:0] angle_o;
    logic signed [DDS_W-1:0]   dds_inc_o;
    logic                      out_valid_o;
    logic                      out_ready_i;

    // one entry per vector line of the stimulus file
    logic [31:0] vec_c0 [$];
    logic [31:0] vec_c1 [$];
    integer      vec_angle [$];
    integer      vec_dds [$];

    integer num_vectors;
    bit     load_done;
    integer error_count;
    integer accept_count;
    integer result_count;
    integer seed;

    cfo_estimator #(
        .ANGLE_W (ANGLE_W),
        .DDS_W   (DDS_W)
    ) u_dut (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .c0_i        (c0_i),
        .c1_i        (c1_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .angle_o     (angle_o),
        .dds_inc_o   (dds_inc_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    // 20 ns period
    always #10 clk_i = ~clk_i;

    task automatic check_value(input string name, input integer actual, input integer expected);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // lines that do not parse as four fields are skipped
    task automatic load_vectors();
        integer           fd;
        integer           code;
        logic [31:0]      c0;
        logic [31:0]      c1;
        integer           ang;
        integer           dds;
        logic [8*160-1:0] skipped;
        fd = $fopen("verification/cfo_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verification/cfo_stimulus.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%h %h %d %d\n", c0, c1, ang, dds);
                if (code == 4) begin
                    vec_c0.push_back(c0);
                    vec_c1.push_back(c1);
                    vec_angle.push_back(ang);
                    vec_dds.push_back(dds);
                end else begin
                    code = $fgets(skipped, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // valid stays up until the DUT takes the pair
    task automatic drive_inputs();
        logic taken;
        for (int i = 0; i < num_vectors; i++) begin
            in_valid_i <= 1'b1;
            c0_i       <= vec_c0[i];
            c1_i       <= vec_c1[i];
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk_i);
                taken = in_ready_o;
                @(posedge clk_i);
            end
            accept_count++;
        end
        in_valid_i <= 1'b0;
    endtask

    // samples at the falling edge and drives out_ready at the rising edge
    task automatic watch_outputs();
        logic   hold_prev;
        logic   busy;
        integer angle_prev;
        integer dds_prev;
        integer exp_angle;
        integer idle_cycles;
        hold_prev   = 1'b0;
        busy        = 1'b0;
        angle_prev  = 0;
        dds_prev    = 0;
        idle_cycles = 0;
        while (idle_cycles < 20) begin
            @(negedge clk_i);
            // result held while the sink stalls
            if (hold_prev) begin
                check_value("out_valid_o", out_valid_o, 1);
                check_value("angle_o", angle_o, angle_prev);
                check_value("dds_inc_o", dds_inc_o, dds_prev);
            end
            if (busy) begin
                check_value("in_ready_o", in_ready_o, 0);
            end
            if (in_valid_i && in_ready_o) begin
                busy = 1'b1;
            end
            if (out_valid_o && out_ready_i) begin
                if (result_count >= accept_count || result_count >= num_vectors) begin
                    $display("result %0d appeared without an accepted input for it",
                             result_count + 1);
                    error_count++;
                end else begin
                    exp_angle = vec_angle[result_count];
                    check_value("angle_o", angle_o, exp_angle);
                    check_value("dds_inc_o", dds_inc_o, exp_angle >>> 6);
                    check_value("dds_inc_o", dds_inc_o, vec_dds[result_count]);
                end
                result_count++;
                busy = 1'b0;
            end
            hold_prev  = out_valid_o && !out_ready_i;
            angle_prev = angle_o;
            dds_prev   = dds_inc_o;
            if (result_count >= num_vectors) begin
                idle_cycles++;
            end
            @(posedge clk_i);
            out_ready_i <= (($random(seed) & 3) != 0);
        end
    endtask

    initial begin
        reset_ni     = 1'b0;
        in_valid_i   = 1'b0;
        c0_i         = '0;
        c1_i         = '0;
        out_ready_i  = 1'b0;
        seed         = 32'h501f;
        error_count  = 0;
        accept_count = 0;
        result_count = 0;
        load_done    = 1'b0;
        load_vectors();
        num_vectors = vec_c0.size();
        load_done   = 1'b1;
        repeat (4) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        check_value("out_valid_o", out_valid_o, 0);
        check_value("in_ready_o", in_ready_o, 1);
        check_value("angle_o", angle_o, 0);
        check_value("dds_inc_o", dds_inc_o, 0);
        @(posedge clk_i);
        if (num_vectors == 0) begin
            $display("no test vectors were read from the stimulus file");
            error_count++;
        end else begin
            fork
                drive_inputs();
                watch_outputs();
            join
        end
        check_value("result count", result_count, num_vectors);
        $display("errors: %0d, results checked: %0d of %0d",
                 error_count, result_count, num_vectors);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // generous bound of 40 cycles per vector
    initial begin
        wait (load_done);
        repeat (num_vectors * 40 + 100) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d clock cycles",
                 num_vectors * 40 + 100);
        $display("errors: %0d, results checked: %0d of %0d",
                 error_count, result_count, num_vectors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/cfo_stimulus.txt
# c0 c1 in hex with the imaginary part in the upper 16 bits, then angle and dds_inc in decimal
# angle full scale is +-pi at 20 bits, dds_inc is the angle shifted right by 6
00002000 00004000 0 0
20000000 00004000 262142 4095
0000e000 00004000 524286 8191
e0000000 00004000 -262142 -4096
20002000 00004000 131071 2047
2000e000 00004000 393215 6143
e000e000 00004000 -393215 -6144
e0002000 00004000 -131071 -2048
10003000 00004000 53695 838
3000e000 00004000 360273 5629
f000d000 00004000 -470591 -7353
00002000 40000000 -262142 -4096
00004000 20002000 -131071 -2048
01000300 00000400 53695 838
00c0ff80 00000100 360273 5629
fff8fff8 00000010 -393215 -6144
00000000 00000000 262142 4095

//--- list.f
logic/cfo_fmt_pkg.sv
logic/cfo_angle_pkg.sv
logic/cfo_if.sv
logic/cfo_control.sv
logic/cfo_normalize.sv
logic/cfo_conj_mult.sv
logic/cfo_divider.sv
logic/cfo_atan.sv
logic/cfo_estimator.sv
verification/tb_cfo_estimator.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of tb_cfo_estimator, started from any directory

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_cfo_estimator \
    --Mdir obj_dir -o tb_cfo_estimator
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cfo_estimator > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" sim.log; then
    exit 0
fi
exit 1
